/* design/bp_pkg.sv */
`default_nettype none

package bp_pkg;

    // Address and history sizes
    localparam int ADDR_BITS      = 32;
    localparam int HIST_BITS      = 4;
    localparam int PHT_ENTRIES    = 16;
    localparam int BTB_INDEX_BITS = 4;
    localparam int BTB_ENTRIES    = 2 ** BTB_INDEX_BITS;
    localparam int TAG_BITS       = 26;

    // Fetch starts here out of reset
    localparam logic [ADDR_BITS-1:0] RESET_PC = '0;

    // 2-bit saturating counter encodings
    localparam logic [1:0] CTR_STRONG_NT = 2'b00;
    localparam logic [1:0] CTR_WEAK_NT   = 2'b01;
    localparam logic [1:0] CTR_STRONG_T  = 2'b11;

    // Word-aligned address split for table lookup
    typedef struct packed {
        logic [TAG_BITS-1:0]       tag;
        logic [BTB_INDEX_BITS-1:0] index;
        logic [1:0]                align;
    } pc_fields_t;

    // Same address seen as a raw word or as its fields
    typedef union packed {
        logic [ADDR_BITS-1:0] raw;
        pc_fields_t           f;
    } pc_addr_u;

    // Branch resolution from execute, 68 bits
    typedef struct packed {
        logic                 branch;
        logic                 taken;
        logic                 jump;
        logic                 btb_hit;
        logic [ADDR_BITS-1:0] pc;
        logic [ADDR_BITS-1:0] target;
    } resolve_t;

endpackage

`default_nettype wire

/* design/gshare_predictor.sv */
`default_nettype none

module gshare_predictor
    import bp_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  resolve_t resolve,
    output logic     taken
);

    // Global history, newest outcome in bit 0
    logic [HIST_BITS-1:0] ghr;

    // Pattern history counters, one per history value
    logic [1:0] pht [PHT_ENTRIES];

    // Counter selected by the current history
    logic [1:0] cur_ctr;
    logic [1:0] upd_ctr;

    assign cur_ctr = pht[ghr];

    // MSB of the counter is the prediction
    assign taken = cur_ctr[1];

    // Saturating step toward the resolved outcome
    always_comb begin
        upd_ctr = cur_ctr;
        if (resolve.taken) begin
            if (cur_ctr != CTR_STRONG_T) begin
                upd_ctr = cur_ctr + 2'd1;
            end
        end else begin
            if (cur_ctr != CTR_STRONG_NT) begin
                upd_ctr = cur_ctr - 2'd1;
            end
        end
    end

    // History shift and counter write on a branch strobe
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ghr <= '0;
            // All counters start weakly not-taken
            for (int i = 0; i < PHT_ENTRIES; i++) begin
                pht[i] <= CTR_WEAK_NT;
            end
        end else if (resolve.branch) begin
            // Counter indexed by the history seen before this outcome
            pht[ghr] <= upd_ctr;
            ghr      <= {ghr[HIST_BITS-2:0], resolve.taken};
        end
    end

endmodule

`default_nettype wire

/* design/branch_target_buffer.sv */
`default_nettype none

module branch_target_buffer
    import bp_pkg::*;
(
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic [ADDR_BITS-1:0] pc,
    input  resolve_t             resolve,
    output logic                 hit,
    output logic [ADDR_BITS-1:0] btb_target
);

    // Fetch address and resolved branch address, both decoded into fields
    pc_addr_u fetch_addr;
    pc_addr_u wr_addr;

    // Entry storage
    logic [TAG_BITS-1:0]  tag_mem    [BTB_ENTRIES];
    logic [ADDR_BITS-1:0] target_mem [BTB_ENTRIES];
    logic [BTB_ENTRIES-1:0] valid;

    // Allocate only taken branches
    logic wr_en;

    assign fetch_addr.raw = pc;
    assign wr_addr.raw    = resolve.pc;

    assign wr_en = resolve.branch && resolve.taken;

    // Lookup at fetch
    assign hit = valid[fetch_addr.f.index]
              && (tag_mem[fetch_addr.f.index] == fetch_addr.f.tag);

    // Target is meaningful only alongside hit
    assign btb_target = target_mem[fetch_addr.f.index];

    // Valid bits
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid <= '0;
        end else if (wr_en) begin
            valid[wr_addr.f.index] <= 1'b1;
        end
    end

    // Tag and target payload
    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[wr_addr.f.index]    <= wr_addr.f.tag;
            // Overwrites any older branch aliasing the same slot
            target_mem[wr_addr.f.index] <= resolve.target;
        end
    end

endmodule

`default_nettype wire

/* design/branch_correction_buffer.sv */
`default_nettype none

module branch_correction_buffer
    import bp_pkg::*;
(
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic [ADDR_BITS-1:0] pc,
    input  logic                 hit,
    input  logic                 taken,
    input  resolve_t             resolve,
    output logic                 wrong,
    output logic [ADDR_BITS-1:0] recover_pc
);

    pc_addr_u fetch_addr;
    pc_addr_u res_addr;

    // Predicted direction per slot, as fetched
    logic [BTB_ENTRIES-1:0] pred;

    // Fall-through address per slot
    logic [ADDR_BITS-1:0] fall_mem [BTB_ENTRIES];

    // Prediction recorded for the resolving branch
    logic rec_pred;

    assign fetch_addr.raw = pc;
    assign res_addr.raw   = resolve.pc;

    assign rec_pred = pred[res_addr.f.index];

    // Only BTB hits were predicted, so only they can be wrong
    assign wrong = resolve.branch && resolve.btb_hit && (rec_pred != resolve.taken);

    // Predicted taken but fell through, or predicted not-taken but jumped
    assign recover_pc = rec_pred ? fall_mem[res_addr.f.index] : resolve.target;

    // Direction record
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pred <= '0;
        end else if (hit) begin
            pred[fetch_addr.f.index] <= taken;
        end
    end

    // Fall-through record
    always_ff @(posedge clk) begin
        if (hit) begin
            fall_mem[fetch_addr.f.index] <= pc + ADDR_BITS'(4);
        end
    end

endmodule

`default_nettype wire

/* design/fetch_pc_select.sv */
`default_nettype none

module fetch_pc_select
    import bp_pkg::*;
(
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 hit,
    input  logic                 taken,
    input  logic                 wrong,
    input  logic [ADDR_BITS-1:0] btb_target,
    input  logic [ADDR_BITS-1:0] recover_pc,
    input  resolve_t             resolve,
    output logic [ADDR_BITS-1:0] pc,
    output logic                 miss_redirect
);

    logic [ADDR_BITS-1:0] pc_next;

    // Execute overrides everything fetch guessed
    logic exec_redirect;

    // Taken branch the BTB never saw
    assign miss_redirect = resolve.branch && resolve.taken && !resolve.btb_hit;

    assign exec_redirect = resolve.jump || miss_redirect;

    // Next PC priority
    always_comb begin
        if (exec_redirect) begin
            pc_next = resolve.target;
        end else if (wrong) begin
            pc_next = recover_pc;
        end else if (hit && taken) begin
            // Predicted taken with a known target
            pc_next = btb_target;
        end else begin
            pc_next = pc + ADDR_BITS'(4);
        end
    end

    // PC advances every cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

endmodule

`default_nettype wire

/* design/global_prediction_top.sv */
`default_nettype none

module global_prediction_top
    import bp_pkg::*;
(
    input  logic                 clk,
    input  logic                 arst_n,
    input  resolve_t             resolve,
    output logic [ADDR_BITS-1:0] pc,
    output logic                 hit,
    output logic                 taken,
    output logic                 wrong,
    output logic                 miss_redirect
);

    // BTB target for the current pc
    logic [ADDR_BITS-1:0] btb_target;

    // Recovery address on a mispredict
    logic [ADDR_BITS-1:0] recover_pc;

    // Direction prediction
    gshare_predictor u_gshare (
        .clk     (clk),
        .arst_n  (arst_n),
        .resolve (resolve),
        .taken   (taken)
    );

    // Target lookup
    branch_target_buffer u_btb (
        .clk        (clk),
        .arst_n     (arst_n),
        .pc         (pc),
        .resolve    (resolve),
        .hit        (hit),
        .btb_target (btb_target)
    );

    // Mispredict detection and recovery address
    branch_correction_buffer u_bcb (
        .clk        (clk),
        .arst_n     (arst_n),
        .pc         (pc),
        .hit        (hit),
        .taken      (taken),
        .resolve    (resolve),
        .wrong      (wrong),
        .recover_pc (recover_pc)
    );

    // PC register and next-address mux
    fetch_pc_select u_pc_sel (
        .clk           (clk),
        .arst_n        (arst_n),
        .hit           (hit),
        .taken         (taken),
        .wrong         (wrong),
        .btb_target    (btb_target),
        .recover_pc    (recover_pc),
        .resolve       (resolve),
        .pc            (pc),
        .miss_redirect (miss_redirect)
    );

endmodule

`default_nettype wire

/* verif/global_prediction_chk.sv */
`default_nettype none

module global_prediction_chk
    import bp_pkg::*;
(
    input logic                 clk,
    input logic                 arst_n,
    input resolve_t             resolve,
    input logic [ADDR_BITS-1:0] pc,
    input logic                 hit,
    input logic                 taken,
    input logic                 wrong,
    input logic                 miss_redirect
);

    timeunit 1ns;
    timeprecision 1ps;

    // Set by any failing assertion, watched by the testbench
    logic failed = 1'b0;

    // Last taken branch seen at resolve
    logic                 sh_valid;
    logic [ADDR_BITS-1:0] sh_pc;
    logic [ADDR_BITS-1:0] sh_target;

    // Last branch fetched with a BTB hit
    logic                 fb_valid;
    logic                 fb_taken;
    logic [ADDR_BITS-1:0] fb_pc;
    logic [ADDR_BITS-1:0] fb_fall;

    // Taken outcomes in a row, saturating at six
    logic [2:0] taken_run;

    // Expected next pc, one flag per rule
    logic                 exp_seq;
    logic                 exp_exec;
    logic                 exp_btb;
    logic                 exp_rec;
    logic [ADDR_BITS-1:0] exp_pc;

    logic miss_now;
    logic exec_now;
    logic seq_now;
    logic btb_now;
    logic rec_now;

    assign miss_now = resolve.branch && resolve.taken && !resolve.btb_hit;
    assign exec_now = resolve.jump || miss_now;
    assign seq_now  = !resolve.branch && !resolve.jump && !wrong && !(hit && taken);
    // Predicted-taken hit on the shadowed branch, nothing else in flight
    assign btb_now  = sh_valid && (pc == sh_pc) && hit && taken
                   && !resolve.branch && !resolve.jump && !wrong;
    // Branch predicted taken at fetch now resolving not-taken
    assign rec_now  = resolve.branch && resolve.btb_hit && !resolve.taken && !resolve.jump
                   && fb_valid && fb_taken && (resolve.pc == fb_pc);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sh_valid  <= 1'b0;
            sh_pc     <= '0;
            sh_target <= '0;
            fb_valid  <= 1'b0;
            fb_taken  <= 1'b0;
            fb_pc     <= '0;
            fb_fall   <= '0;
            taken_run <= '0;
            exp_seq   <= 1'b0;
            exp_exec  <= 1'b0;
            exp_btb   <= 1'b0;
            exp_rec   <= 1'b0;
            exp_pc    <= '0;
        end else begin
            if (resolve.branch && resolve.taken) begin
                sh_valid  <= 1'b1;
                sh_pc     <= resolve.pc;
                sh_target <= resolve.target;
            end
            // Four fill the history, two more lift its counter past the midpoint
            if (resolve.branch) begin
                if (!resolve.taken) begin
                    taken_run <= '0;
                end else if (taken_run != 3'd6) begin
                    taken_run <= taken_run + 3'd1;
                end
            end
            if (hit) begin
                fb_valid <= 1'b1;
                fb_taken <= taken;
                fb_pc    <= pc;
                fb_fall  <= pc + 32'd4;
            end
            exp_seq  <= seq_now;
            exp_exec <= exec_now;
            exp_btb  <= btb_now;
            exp_rec  <= rec_now;
            // Priority mirrors the redirect order
            if (exec_now) begin
                exp_pc <= resolve.target;
            end else if (rec_now) begin
                exp_pc <= fb_fall;
            end else if (btb_now) begin
                exp_pc <= sh_target;
            end else begin
                exp_pc <= pc + 32'd4;
            end
        end
    end

    // Reset state
    a_reset: assert property (@(posedge clk)
        !arst_n |-> (pc == RESET_PC) && !hit && !wrong && !miss_redirect)
        else begin
            failed = 1'b1;
            $error("FAIL pc %h hit %h wrong %h under reset", pc, hit, wrong);
        end

    // Sequential fetch
    a_seq: assert property (@(posedge clk) disable iff (!arst_n)
        exp_seq |-> pc == exp_pc)
        else begin
            failed = 1'b1;
            $error("FAIL pc %h expected %h after sequential step", pc, exp_pc);
        end

    // Execute redirect and the miss flag
    a_miss: assert property (@(posedge clk) disable iff (!arst_n)
        miss_redirect == miss_now)
        else begin
            failed = 1'b1;
            $error("FAIL miss_redirect %h expected %h", miss_redirect, miss_now);
        end

    a_exec: assert property (@(posedge clk) disable iff (!arst_n)
        exp_exec |-> pc == exp_pc)
        else begin
            failed = 1'b1;
            $error("FAIL pc %h expected %h after execute redirect", pc, exp_pc);
        end

    // Known taken branch hits the BTB
    a_hit: assert property (@(posedge clk) disable iff (!arst_n)
        (sh_valid && pc == sh_pc) |-> hit)
        else begin
            failed = 1'b1;
            $error("FAIL hit %h at pc %h", hit, pc);
        end

    // All-taken history predicts taken
    a_taken: assert property (@(posedge clk) disable iff (!arst_n)
        (taken_run == 3'd6) |-> taken)
        else begin
            failed = 1'b1;
            $error("FAIL taken %h expected 1 after a run of taken branches", taken);
        end

    a_btb: assert property (@(posedge clk) disable iff (!arst_n)
        exp_btb |-> pc == exp_pc)
        else begin
            failed = 1'b1;
            $error("FAIL pc %h expected BTB target %h", pc, exp_pc);
        end

    // Wrongly predicted taken recovers to fall-through
    a_wrong_set: assert property (@(posedge clk) disable iff (!arst_n)
        rec_now |-> wrong)
        else begin
            failed = 1'b1;
            $error("FAIL wrong %h on mispredicted branch %h", wrong, resolve.pc);
        end

    a_recover: assert property (@(posedge clk) disable iff (!arst_n)
        exp_rec |-> pc == exp_pc)
        else begin
            failed = 1'b1;
            $error("FAIL pc %h expected recovery %h", pc, exp_pc);
        end

    // wrong needs a strobe with btb_hit
    a_wrong_src: assert property (@(posedge clk) disable iff (!arst_n)
        wrong |-> resolve.branch && resolve.btb_hit)
        else begin
            failed = 1'b1;
            $error("wrong raised without a resolving BTB-hit branch");
        end

endmodule

`default_nettype wire

/* verif/global_prediction_tb.sv */
`default_nettype none

module global_prediction_tb
    import bp_pkg::*;
;

    timeunit 1ns;
    timeprecision 1ps;

    // Loop branch and its body, second branch for random outcomes
    localparam logic [31:0] LOOP_TOP = 32'h0000_0100;
    localparam logic [31:0] LOOP_BR  = 32'h0000_0110;
    localparam logic [31:0] RAND_TOP = 32'h0000_0200;
    localparam logic [31:0] RAND_BR  = 32'h0000_0208;
    localparam int LOOP_ITERS = 30;
    localparam int RAND_ITERS = 60;
    // Roughly 600 cycles of stimulus, ample margin
    localparam int MAX_CYCLES = 2000;

    logic                 clk;
    logic                 arst_n;
    resolve_t             resolve;
    logic [ADDR_BITS-1:0] pc;
    logic                 hit;
    logic                 taken;
    logic                 wrong;
    logic                 miss_redirect;

    logic [31:0] rng;
    int          cycles = 0;
    logic        seen_hit;
    logic        outcome;

    global_prediction_top uut (
        .clk           (clk),
        .arst_n        (arst_n),
        .resolve       (resolve),
        .pc            (pc),
        .hit           (hit),
        .taken         (taken),
        .wrong         (wrong),
        .miss_redirect (miss_redirect)
    );

    bind global_prediction_top global_prediction_chk u_chk (
        .clk           (clk),
        .arst_n        (arst_n),
        .resolve       (resolve),
        .pc            (pc),
        .hit           (hit),
        .taken         (taken),
        .wrong         (wrong),
        .miss_redirect (miss_redirect)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1);
    endtask

    // Sample at the falling edge, where pc and hit are settled
    task automatic wait_for_pc(input logic [31:0] addr, output logic was_hit);
        do begin
            @(negedge clk);
        end while (pc != addr);
        was_hit = hit;
    endtask

    // One-cycle branch strobe from execute
    task automatic resolve_branch(input logic [31:0] br_pc, input logic [31:0] tgt,
                                  input logic tk, input logic bh);
        @(posedge clk);
        resolve.branch  <= 1'b1;
        resolve.taken   <= tk;
        resolve.jump    <= 1'b0;
        resolve.btb_hit <= bh;
        resolve.pc      <= br_pc;
        resolve.target  <= tgt;
        @(posedge clk);
        resolve <= '0;
    endtask

    task automatic resolve_jump(input logic [31:0] tgt);
        @(posedge clk);
        resolve.jump   <= 1'b1;
        resolve.target <= tgt;
        @(posedge clk);
        resolve <= '0;
    endtask

    // Timeout guard
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            stop_with_failure("Timeout, the run did not finish in time");
        end
    end

    // First assertion failure ends the run
    always @(negedge clk) begin
        if (uut.u_chk.failed) begin
            stop_with_failure("An assertion in the checker failed");
        end
    end

    initial begin
        arst_n  = 1'b0;
        resolve = '0;
        rng     = 32'd28;
        repeat (10) @(posedge clk);
        arst_n <= 1'b1;

        // Plain sequential fetch
        repeat (20) @(posedge clk);

        // Jump into the loop body
        resolve_jump(LOOP_TOP);

        // Loop branch trains BTB and PHT toward taken
        for (int i = 0; i < LOOP_ITERS; i++) begin
            wait_for_pc(LOOP_BR, seen_hit);
            resolve_branch(LOOP_BR, LOOP_TOP, 1'b1, seen_hit);
        end
        // Loop exit, predicted taken so it is a mispredict
        wait_for_pc(LOOP_BR, seen_hit);
        resolve_branch(LOOP_BR, LOOP_TOP, 1'b0, seen_hit);

        // Random outcomes on a second branch
        resolve_jump(RAND_TOP);
        for (int i = 0; i < RAND_ITERS; i++) begin
            wait_for_pc(RAND_BR, seen_hit);
            rng = xorshift32(rng);
            outcome = rng[7];
            resolve_branch(RAND_BR, RAND_TOP, outcome, seen_hit);
            if (!outcome) begin
                resolve_jump(RAND_TOP);
            end
        end

        repeat (5) @(posedge clk);
        @(negedge clk);
        if (!uut.u_chk.failed) begin
            $display("TB PASSED");
            $finish;
        end else begin
            stop_with_failure("An assertion in the checker failed");
        end
    end

endmodule

`default_nettype wire

/* sim.f */
design/bp_pkg.sv
design/gshare_predictor.sv
design/branch_target_buffer.sv
design/branch_correction_buffer.sv
design/fetch_pc_select.sv
design/global_prediction_top.sv
verif/global_prediction_chk.sv
verif/global_prediction_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f sim.f --top-module global_prediction_tb
	./obj_dir/Vglobal_prediction_tb | tee /dev/stderr | grep -q "TB PASSED"

clean:
	rm -rf obj_dir
